// File: ex_arith.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_arith (
    input  wire mips_isa_pkg::aluop_e  aluop_i,
    input  wire [`REG_WIDTH-1:0]       reg1_i,
    input  wire [`REG_WIDTH-1:0]       reg2_i,
    output logic [`REG_WIDTH-1:0]      arith_o,
    output logic                       ov_drop_o
);
    import mips_isa_pkg::*;

    localparam int MSB       = `REG_WIDTH - 1;
    localparam int CNT_WIDTH = $clog2(`REG_WIDTH + 1);

    logic                  is_sub;
    logic                  is_trap_op;
    logic [`REG_WIDTH-1:0] reg2_mux;
    logic [`REG_WIDTH-1:0] sum;
    logic                  b_sign;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic [CNT_WIDTH-1:0]  lead_cnt;

    // leading bits equal to ones, scanned from the msb
    function automatic logic [CNT_WIDTH-1:0] count_lead(
        input logic [`REG_WIDTH-1:0] word,
        input logic                  ones
    );
        logic [CNT_WIDTH-1:0] cnt;
        logic                 done;
        cnt  = CNT_WIDTH'(`REG_WIDTH);
        done = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (!done && (word[i] != ones)) begin
                cnt  = CNT_WIDTH'(MSB - i);
                done = 1'b1;
            end
        end
        return cnt;
    endfunction

    // slt is done as reg1 - reg2 as well
    assign is_sub = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) || (aluop_i == OP_SLT);
    assign reg2_mux = is_sub ? (~reg2_i + 1'b1) : reg2_i;
    assign sum = reg1_i + reg2_mux;

    // sign of the effective second operand, right even for reg2 = 0x80000000
    assign b_sign = is_sub ? ~reg2_i[MSB] : reg2_i[MSB];

    assign lt_signed = (reg1_i[MSB] & ~reg2_i[MSB])
                     | ((reg1_i[MSB] == reg2_i[MSB]) & sum[MSB]);
    assign lt_unsigned = reg1_i < reg2_i;

    assign lead_cnt = count_lead(reg1_i, aluop_i == OP_CLO);

    // only the trapping add/sub drop their result
    assign is_trap_op = (aluop_i == OP_ADD) || (aluop_i == OP_SUB);
    assign ov_drop_o  = is_trap_op && (reg1_i[MSB] == b_sign) && (sum[MSB] != reg1_i[MSB]);

    always_comb begin
        case (aluop_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_o = sum;
            OP_SLT:          arith_o = {{MSB{1'b0}}, lt_signed};
            OP_SLTU:         arith_o = {{MSB{1'b0}}, lt_unsigned};
            OP_CLZ, OP_CLO:  arith_o = {{(`REG_WIDTH - CNT_WIDTH){1'b0}}, lead_cnt};
            default:         arith_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: ex_hilo_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_hilo_unit (
    input  wire mips_isa_pkg::aluop_e     aluop_i,
    input  wire [`REG_WIDTH-1:0]          reg1_i,
    input  wire ex_pipe_pkg::hilo_t       hilo_i,
    input  wire ex_pipe_pkg::hilo_wr_t    mem_fwd_i,
    input  wire ex_pipe_pkg::hilo_wr_t    wb_fwd_i,
    input  wire [`DREG_WIDTH-1:0]         product_i,
    output logic [`REG_WIDTH-1:0]         move_o,
    output ex_pipe_pkg::hilo_wr_t         hilo_wr_o
);
    import mips_isa_pkg::*;
    import ex_pipe_pkg::*;

    hilo_t cur_hilo;

    // mem is younger than wb, so it wins
    always_comb begin
        if (mem_fwd_i.we) begin
            cur_hilo = mem_fwd_i.hilo;
        end else if (wb_fwd_i.we) begin
            cur_hilo = wb_fwd_i.hilo;
        end else begin
            cur_hilo = hilo_i;
        end
    end

    always_comb begin
        case (aluop_i)
            OP_MFHI:          move_o = cur_hilo.hi;
            OP_MFLO:          move_o = cur_hilo.lo;
            OP_MOVZ, OP_MOVN: move_o = reg1_i; // condition checked in decode
            default:          move_o = '0;
        endcase
    end

    always_comb begin
        hilo_wr_o = '0;
        case (aluop_i)
            OP_MTHI: begin
                hilo_wr_o.we      = 1'b1;
                hilo_wr_o.hilo.hi = reg1_i;
                hilo_wr_o.hilo.lo = cur_hilo.lo;  // other half kept from bypassed pair
            end
            OP_MTLO: begin
                hilo_wr_o.we      = 1'b1;
                hilo_wr_o.hilo.hi = cur_hilo.hi;
                hilo_wr_o.hilo.lo = reg1_i;
            end
            OP_MULT, OP_MULTU: begin
                hilo_wr_o.we      = 1'b1;
                hilo_wr_o.hilo.hi = product_i[`DREG_WIDTH-1:`REG_WIDTH];
                hilo_wr_o.hilo.lo = product_i[`REG_WIDTH-1:0];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ex_logic_shift.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_logic_shift (
    input  wire mips_isa_pkg::aluop_e  aluop_i,
    input  wire [`REG_WIDTH-1:0]       reg1_i,
    input  wire [`REG_WIDTH-1:0]       reg2_i,
    output logic [`REG_WIDTH-1:0]      logic_o,
    output logic [`REG_WIDTH-1:0]      shift_o
);
    import mips_isa_pkg::*;

    logic [`SHAMT_WIDTH-1:0] shamt;

    assign shamt = reg1_i[`SHAMT_WIDTH-1:0];

    // bitwise ops
    always_comb begin
        case (aluop_i)
            OP_AND:  logic_o = reg1_i & reg2_i;
            OP_OR:   logic_o = reg1_i | reg2_i;
            OP_XOR:  logic_o = reg1_i ^ reg2_i;
            OP_NOR:  logic_o = ~(reg1_i | reg2_i);
            OP_LUI:  logic_o = reg2_i;  // immediate already moved up by decode
            default: logic_o = '0;
        endcase
    end

    // reg2 is the value, reg1 carries the amount
    always_comb begin
        case (aluop_i)
            OP_SLL:  shift_o = reg2_i << shamt;
            OP_SRL:  shift_o = reg2_i >> shamt;
            OP_SRA:  shift_o = $unsigned($signed(reg2_i) >>> shamt); // sign of reg2 fills in
            default: shift_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: ex_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_mult (
    input  wire mips_isa_pkg::aluop_e  aluop_i,
    input  wire [`REG_WIDTH-1:0]       reg1_i,
    input  wire [`REG_WIDTH-1:0]       reg2_i,
    output logic [`DREG_WIDTH-1:0]     product_o
);
    import mips_isa_pkg::*;

    localparam int MSB = `REG_WIDTH - 1;

    logic                   is_signed;
    logic                   neg_result;
    logic [`REG_WIDTH-1:0]  op1_mag;
    logic [`REG_WIDTH-1:0]  op2_mag;
    logic [`DREG_WIDTH-1:0] mag_product;

    assign is_signed = (aluop_i == OP_MULT) || (aluop_i == OP_MUL);

    // magnitudes of negative operands, multu keeps the raw words
    assign op1_mag = (is_signed && reg1_i[MSB]) ? (~reg1_i + 1'b1) : reg1_i;
    assign op2_mag = (is_signed && reg2_i[MSB]) ? (~reg2_i + 1'b1) : reg2_i;

    assign mag_product = op1_mag * op2_mag; // unsigned 32x32 -> 64

    assign neg_result = is_signed && (reg1_i[MSB] ^ reg2_i[MSB]);

    // back to two's complement when signs differ
    assign product_o = neg_result ? (~mag_product + 1'b1) : mag_product;

endmodule

`default_nettype wire

// File: ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// general purpose register word
`define REG_WIDTH 32

// register file address
`define REG_ADDR_WIDTH 5

// low bits of operand 1 used as shift amount
`define SHAMT_WIDTH 5

// hi/lo pair and full multiplier product
`define DREG_WIDTH 64

`endif

// File: ex_pipe_pkg.sv
`default_nettype none

`include "ex_params.svh"

package ex_pipe_pkg;

    // instruction handed over by decode
    typedef struct packed {
        mips_isa_pkg::aluop_e       aluop;
        mips_isa_pkg::alusel_e      alusel;
        logic [`REG_WIDTH-1:0]      reg1;
        logic [`REG_WIDTH-1:0]      reg2;
        logic                       wreg;   // movz/movn condition already folded in
        logic [`REG_ADDR_WIDTH-1:0] waddr;
    } ex_req_t;

    typedef struct packed {
        logic [`REG_WIDTH-1:0] hi;
        logic [`REG_WIDTH-1:0] lo;
    } hilo_t;

    // hi/lo write, also used as bypass from mem and wb
    typedef struct packed {
        logic  we;
        hilo_t hilo;
    } hilo_wr_t;

    // gpr write toward mem
    typedef struct packed {
        logic                       we;
        logic [`REG_ADDR_WIDTH-1:0] waddr;
        logic [`REG_WIDTH-1:0]      wdata;
    } gpr_wr_t;

endpackage

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  wire ex_pipe_pkg::ex_req_t     req_i,
    input  wire ex_pipe_pkg::hilo_t       hilo_i,
    input  wire ex_pipe_pkg::hilo_wr_t    mem_fwd_i,
    input  wire ex_pipe_pkg::hilo_wr_t    wb_fwd_i,
    output ex_pipe_pkg::gpr_wr_t          gpr_wr_o,
    output ex_pipe_pkg::hilo_wr_t         hilo_wr_o
);
    import mips_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic [`REG_WIDTH-1:0]  logic_res;
    logic [`REG_WIDTH-1:0]  shift_res;
    logic [`REG_WIDTH-1:0]  arith_res;
    logic [`REG_WIDTH-1:0]  move_res;
    logic [`DREG_WIDTH-1:0] product;
    logic                   ov_drop;
    gpr_wr_t                gpr_nxt;
    hilo_wr_t               hilo_nxt;

    ex_logic_shift ex_logic_shift_i (
        .aluop_i (req_i.aluop),
        .reg1_i  (req_i.reg1),
        .reg2_i  (req_i.reg2),
        .logic_o (logic_res),
        .shift_o (shift_res)
    );

    ex_arith ex_arith_i (
        .aluop_i   (req_i.aluop),
        .reg1_i    (req_i.reg1),
        .reg2_i    (req_i.reg2),
        .arith_o   (arith_res),
        .ov_drop_o (ov_drop)
    );

    ex_mult ex_mult_i (
        .aluop_i   (req_i.aluop),
        .reg1_i    (req_i.reg1),
        .reg2_i    (req_i.reg2),
        .product_o (product)
    );

    ex_hilo_unit ex_hilo_unit_i (
        .aluop_i   (req_i.aluop),
        .reg1_i    (req_i.reg1),
        .hilo_i    (hilo_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .product_i (product),
        .move_o    (move_res),
        .hilo_wr_o (hilo_nxt)
    );

    // gpr write record, overflowing add/sub write nothing
    always_comb begin
        gpr_nxt.we    = req_i.wreg & ~ov_drop;
        gpr_nxt.waddr = req_i.waddr;
        case (req_i.alusel)
            SEL_LOGIC: gpr_nxt.wdata = logic_res;
            SEL_SHIFT: gpr_nxt.wdata = shift_res;
            SEL_MOVE:  gpr_nxt.wdata = move_res;
            SEL_ARITH: gpr_nxt.wdata = arith_res;
            SEL_MUL:   gpr_nxt.wdata = product[`REG_WIDTH-1:0]; // mul keeps low word
            default:   gpr_nxt.wdata = '0;
        endcase
    end

    // ex/mem register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gpr_wr_o  <= '0;
            hilo_wr_o <= '0;
        end else begin
            gpr_wr_o  <= gpr_nxt;
            hilo_wr_o <= hilo_nxt;
        end
    end

endmodule

`default_nettype wire

// File: mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // alu operation codes, one per instruction executed here
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_LUI   = 8'b0101_1100,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MOVZ  = 8'b0000_1010,
        OP_MOVN  = 8'b0000_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADD   = 8'b0010_0000, // traps on overflow
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010, // traps on overflow
        OP_SUBU  = 8'b0010_0011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MUL   = 8'b1010_1001  // low word into gpr only
    } aluop_e;

    // which unit feeds the gpr write
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

endpackage

`default_nettype wire

// File: project.f
+incdir+.
mips_isa_pkg.sv
ex_pipe_pkg.sv
ex_logic_shift.sv
ex_arith.sv
ex_mult.sv
ex_hilo_unit.sv
ex_stage.sv
tb_ex_stage.sv

// File: tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module tb_ex_stage;
    import mips_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000; // about 1000 vectors, reset and margin

    typedef struct packed {
        gpr_wr_t  gpr;
        hilo_wr_t hilo;
    } exp_t;

    logic     clk_i = 1'b0;
    logic     rst_n_i;
    ex_req_t  req_i;
    hilo_t    hilo_i;
    hilo_wr_t mem_fwd_i;
    hilo_wr_t wb_fwd_i;
    gpr_wr_t  gpr_wr_o;
    hilo_wr_t hilo_wr_o;
    exp_t     exp_q[$];
    string    name_q[$];
    exp_t     exp_cur;
    string    name_cur;
    int       cycles = 0;

    // logic/shift 0..7, arith 8..15, multiply 16..18, hi/lo and moves 19..24
    aluop_e all_ops[26] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI, OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO, OP_MULT, OP_MULTU,
        OP_MUL, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVZ, OP_MOVN, OP_NOP};

    ex_stage ex_stage_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .hilo_i    (hilo_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .gpr_wr_o  (gpr_wr_o),
        .hilo_wr_o (hilo_wr_o)
    );

    always #50 clk_i = ~clk_i;

    // expected gpr and hi/lo records from the ISA rules
    function automatic exp_t ref_ex(ex_req_t req, hilo_t hl, hilo_wr_t mem, hilo_wr_t wb);
        exp_t                   e;
        hilo_t                  cur;
        logic [`REG_WIDTH-1:0]  a;
        logic [`REG_WIDTH-1:0]  b;
        logic [`REG_WIDTH-1:0]  d;
        logic [`DREG_WIDTH-1:0] sprod;
        logic [`DREG_WIDTH-1:0] uprod;
        logic                   ov;
        int                     n;
        a = req.reg1;
        b = req.reg2;
        e = '0;
        d = '0;
        ov = 1'b0;
        n = 0;
        cur = mem.we ? mem.hilo : (wb.we ? wb.hilo : hl); // mem first, then wb
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'h0, a} * {32'h0, b};
        case (req.aluop)
            OP_AND:  d = a & b;
            OP_OR:   d = a | b;
            OP_XOR:  d = a ^ b;
            OP_NOR:  d = ~(a | b);
            OP_LUI:  d = b;
            OP_SLL:  d = b << a[4:0];
            OP_SRL:  d = b >> a[4:0];
            OP_SRA:  d = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
            OP_ADD, OP_ADDU: begin
                d  = a + b;
                ov = (req.aluop == OP_ADD) && (a[31] == b[31]) && (d[31] != a[31]);
            end
            OP_SUB, OP_SUBU: begin
                d  = a - b;
                ov = (req.aluop == OP_SUB) && (a[31] != b[31]) && (d[31] != a[31]);
            end
            OP_SLT:  d = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: d = (a < b) ? 32'd1 : 32'd0;
            OP_CLZ, OP_CLO: begin
                while (n < 32 && a[31-n] == (req.aluop == OP_CLO)) n++;
                d = n;
            end
            OP_MFHI: d = cur.hi;
            OP_MFLO: d = cur.lo;
            OP_MOVZ, OP_MOVN: d = a;
            OP_MUL:   d = sprod[31:0];
            OP_MULT:  e.hilo = {1'b1, sprod};
            OP_MULTU: e.hilo = {1'b1, uprod};
            OP_MTHI:  e.hilo = {1'b1, a, cur.lo};
            OP_MTLO:  e.hilo = {1'b1, cur.hi, a};
            default: ;
        endcase
        e.gpr = {req.wreg & ~ov, req.waddr, d};
        return e;
    endfunction

    // result class as decode would give it
    function automatic alusel_e sel_for(input aluop_e op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_LUI: return SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                return SEL_SHIFT;
            OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN:    return SEL_MOVE;
            OP_MUL:                                return SEL_MUL;
            OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO:   return SEL_NOP;
            OP_NOP:                                return SEL_NOP;
            default:                               return SEL_ARITH;
        endcase
    endfunction

    function automatic logic [`REG_WIDTH-1:0] pick_operand();
        case ($urandom_range(0, 5))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000; // sign bit alone
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [64:0] expected,
                             input logic [64:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
            stop_with_failure();
        end
    endtask

    // one instruction per cycle, driven 5 ns after the edge
    task automatic run_op(input string name, input aluop_e op, input logic [31:0] r1,
                          input logic [31:0] r2, input logic [1:0] fwd_we);
        ex_req_t  req;
        hilo_t    hl;
        hilo_wr_t mem;
        hilo_wr_t wb;
        req.aluop  = op;
        req.alusel = sel_for(op);
        req.reg1   = r1;
        req.reg2   = r2;
        req.wreg   = (op == OP_MOVZ || op == OP_MOVN) ? 1'($urandom) : (req.alusel != SEL_NOP);
        req.waddr  = $urandom_range(0, 31);
        hl  = {$urandom, $urandom};
        mem = {fwd_we[1], $urandom, $urandom};
        wb  = {fwd_we[0], $urandom, $urandom};
        @(posedge clk_i);
        #5;
        req_i     = req;
        hilo_i    = hl;
        mem_fwd_i = mem;
        wb_fwd_i  = wb;
        exp_q.push_back(ref_ex(req, hl, mem, wb));
        name_q.push_back(name);
    endtask

    // each result is due one edge after its drive
    always @(posedge clk_i) begin
        #1;
        if (exp_q.size() > 0) begin
            exp_cur  = exp_q.pop_front();
            name_cur = name_q.pop_front();
            check_val({name_cur, " gpr_wr"}, exp_cur.gpr, gpr_wr_o);
            check_val({name_cur, " hilo_wr"}, exp_cur.hilo, hilo_wr_o);
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Error: timeout, the tests did not finish within %0d cycles", cycles);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(21));
        rst_n_i   = 1'b0;
        req_i     = '0;
        hilo_i    = '0;
        mem_fwd_i = '0;
        wb_fwd_i  = '0;
        // outputs must stay zero under a busy multiply
        req_i.aluop  = OP_MULT;
        req_i.alusel = SEL_MUL;
        req_i.reg1   = 32'h1234_5678;
        req_i.reg2   = 32'h8765_4321;
        req_i.wreg   = 1'b1;
        req_i.waddr  = 5'd9;
        repeat (10) begin
            @(posedge clk_i);
            #2;
            check_val("reset gpr_wr", '0, gpr_wr_o);
            check_val("reset hilo_wr", '0, hilo_wr_o);
        end
        #3;
        rst_n_i = 1'b1;
        req_i   = '0;
        exp_q.push_back(exp_t'(0)); // idle request on the first edge after release
        name_q.push_back("reset release");
        repeat (200) run_op("logic_shift", all_ops[$urandom_range(0, 7)],
                            pick_operand(), pick_operand(), 2'($urandom));
        run_op("add overflow", OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 2'b00);
        run_op("add overflow", OP_ADD, 32'h8000_0000, 32'h8000_0000, 2'b00);
        run_op("sub overflow", OP_SUB, 32'h8000_0000, 32'h0000_0001, 2'b00);
        run_op("sub overflow", OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 2'b00);
        repeat (200) run_op("arith", all_ops[$urandom_range(8, 15)],
                            pick_operand(), pick_operand(), 2'($urandom));
        repeat (200) run_op("multiply", all_ops[$urandom_range(16, 18)],
                            pick_operand(), pick_operand(), 2'($urandom));
        for (int fwd = 0; fwd < 4; fwd++) begin
            repeat (48) run_op("hilo_bypass", all_ops[$urandom_range(19, 24)],
                               pick_operand(), pick_operand(), 2'(fwd));
        end
        repeat (200) run_op("stream", all_ops[$urandom_range(0, 25)],
                            pick_operand(), pick_operand(), 2'($urandom));
        @(posedge clk_i);
        #2;
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected results were never compared", exp_q.size());
            stop_with_failure();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire
